// ==== design/chienCorrector.sv ====
`timescale 1ns/10ps

module chienCorrector #(
    parameter int ChunkBeats = 16
) (
    input  logic                          i_clk,
    input  logic                          i_rstN,
    input  logic                          i_elpValid,
    input  decPkg::elp_t                  i_elp,
    input  logic                          i_forward,
    output logic                          o_rdEn,
    output logic [$clog2(ChunkBeats)-1:0] o_rdAddr,
    input  decPkg::half_t                 i_rdData,
    output logic                          o_beatValid,
    output decPkg::halfBeat_t             o_beat,
    input  logic                          i_beatReady,
    output logic                          o_release
);
    import gfPkg::*;
    import decPkg::*;

    localparam int AddrWidth = $clog2(ChunkBeats);

    elp_t                     elpReg;
    logic                     fwdReg;
    gfElem_t [0:NumElpCoef-1] coef;
    logic                     running;
    logic [AddrWidth-1:0]     nextAddr;
    logic                     rdPend;
    logic [AddrWidth-1:0]     rdBeat;
    logic                     advance;
    half_t                    flipMask;
    halfBeat_t                outBeat;
    logic                     outValid;
    logic                     relPulse;

    assign coef     = elpReg;
    assign advance  = !outValid || i_beatReady;
    assign o_rdEn   = running && (!rdPend || advance);   // one read ahead at most.
    assign o_rdAddr = nextAddr;

    // scale sigma_i by alpha^(-16bi) once, then step through the sixteen bits.
    always_comb begin : rootSearch
        gfElem_t [1:CorrCap] scaled;
        gfElem_t             eval;
        for (int i = 1; i <= CorrCap; i++) begin
            scaled[i] = gfMul(coef[i], gfAlphaPow(FieldOrder * CorrCap - HalfWidth * i * rdBeat));
        end
        for (int j = 0; j < HalfWidth; j++) begin
            eval = coef[0];
            for (int i = 1; i <= CorrCap; i++) begin
                eval = eval ^ gfMul(scaled[i], gfAlphaPow(FieldOrder * CorrCap - i * j));
            end
            flipMask[j] = (eval == '0) && !fwdReg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_elpValid) begin
            elpReg <= i_elp;
            fwdReg <= i_forward;
        end
        if (o_rdEn) begin
            rdBeat <= nextAddr;
        end
        if (advance && rdPend) begin
            outBeat.data <= i_rdData ^ flipMask;
            outBeat.last <= (rdBeat == AddrWidth'(ChunkBeats - 1));
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            running  <= 1'b0;
            nextAddr <= '0;
            rdPend   <= 1'b0;
            outValid <= 1'b0;
            relPulse <= 1'b0;
        end else begin
            relPulse <= outValid && i_beatReady && outBeat.last;
            if (i_elpValid) begin
                running  <= 1'b1;
                nextAddr <= '0;
            end else if (o_rdEn) begin
                if (nextAddr == AddrWidth'(ChunkBeats - 1)) begin
                    running  <= 1'b0;
                    nextAddr <= '0;
                end else begin
                    nextAddr <= nextAddr + 1'b1;
                end
            end
            if (o_rdEn) begin
                rdPend <= 1'b1;
            end else if (advance) begin
                rdPend <= 1'b0;
            end
            if (advance) begin
                outValid <= rdPend;
            end
        end
    end

    assign o_beatValid = outValid;
    assign o_beat      = outBeat;
    assign o_release   = relPulse;

    assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_beatValid && !i_beatReady |=> o_beatValid && $stable(o_beat))
        else $error("chienCorrector beat changed while stalled");

endmodule

// ==== design/decPkg.sv ====
package decPkg;

    localparam int HalfWidth = 16;
    localparam int WordWidth = 32;

    // BCH correction capability and derived counts.
    localparam int CorrCap      = 4;
    localparam int NumSyndromes = 2 * CorrCap;
    localparam int NumElpCoef   = CorrCap + 1;

    typedef logic [HalfWidth-1:0] half_t;
    typedef logic [WordWidth-1:0] word_t;

    // s1 sits in the top bits.
    typedef struct packed {
        gfPkg::gfElem_t s1;
        gfPkg::gfElem_t s2;
        gfPkg::gfElem_t s3;
        gfPkg::gfElem_t s4;
        gfPkg::gfElem_t s5;
        gfPkg::gfElem_t s6;
        gfPkg::gfElem_t s7;
        gfPkg::gfElem_t s8;
    } syndromes_t;

    // error locator, sigma0 is the constant term.
    typedef struct packed {
        gfPkg::gfElem_t sigma0;
        gfPkg::gfElem_t sigma1;
        gfPkg::gfElem_t sigma2;
        gfPkg::gfElem_t sigma3;
        gfPkg::gfElem_t sigma4;
    } elp_t;

    typedef struct packed {
        half_t data;
        logic  last;
    } halfBeat_t;

endpackage

// ==== design/downConverter.sv ====
`timescale 1ns/10ps

module downConverter (
    input  logic          i_clk,
    input  logic          i_rstN,
    input  logic          i_srcValid,
    input  decPkg::word_t i_srcData,
    output logic          o_srcReady,
    output logic          o_beatValid,
    output decPkg::half_t o_beat,
    input  logic          i_beatReady
);
    import decPkg::*;

    word_t wordReg;
    logic  full;
    logic  hiSel;
    logic  srcReady;
    logic  srcTake;

    assign srcTake     = i_srcValid && srcReady;
    assign o_srcReady  = srcReady;
    assign o_beatValid = full;
    assign o_beat      = hiSel ? wordReg[WordWidth-1:HalfWidth] : wordReg[HalfWidth-1:0];

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            full     <= 1'b0;
            hiSel    <= 1'b0;
            srcReady <= 1'b0;
        end else if (srcTake) begin
            full     <= 1'b1;
            hiSel    <= 1'b0;   // low half goes first.
            srcReady <= 1'b0;
        end else if (full && i_beatReady) begin
            hiSel <= ~hiSel;
            if (hiSel) begin
                full     <= 1'b0;
                srcReady <= 1'b1;
            end
        end else if (!full) begin
            srcReady <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (srcTake) begin
            wordReg <= i_srcData;
        end
    end

    // a stalled half must not move.
    assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_beatValid && !i_beatReady |=> o_beatValid && $stable(o_beat))
        else $error("downConverter beat changed while stalled");

endmodule

// ==== design/gfPkg.sv ====
package gfPkg;

    localparam int GfDegree = 9;
    localparam int FieldOrder = (1 << GfDegree) - 1;   // nonzero elements, 511.

    // x^9 + x^4 + 1.
    localparam logic [GfDegree:0] PrimPoly = 10'h211;

    typedef logic [GfDegree-1:0] gfElem_t;

    // shift-and-add multiply with reduction on every shift.
    function automatic gfElem_t gfMul(gfElem_t a, gfElem_t b);
        gfElem_t acc;
        gfElem_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < GfDegree; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = {sh[GfDegree-2:0], 1'b0} ^ (sh[GfDegree-1] ? PrimPoly[GfDegree-1:0] : '0);
        end
        return acc;
    endfunction

    // square-and-multiply on the reduced exponent.
    function automatic gfElem_t gfAlphaPow(int unsigned e);
        int unsigned r;
        gfElem_t     res;
        gfElem_t     base;
        r    = e % FieldOrder;
        res  = 9'd1;
        base = 9'd2;   // alpha.
        for (int i = 0; i < GfDegree; i++) begin
            if (r[i]) begin
                res = gfMul(res, base);
            end
            base = gfMul(base, base);
        end
        return res;
    endfunction

endpackage

// ==== design/messageBuffer.sv ====
`timescale 1ns/10ps

module messageBuffer #(
    parameter int ChunkBeats = 16
) (
    input  logic                          i_clk,
    input  logic                          i_wrEn,
    input  logic [$clog2(ChunkBeats)-1:0] i_wrAddr,
    input  decPkg::half_t                 i_wrData,
    input  logic                          i_rdEn,
    input  logic [$clog2(ChunkBeats)-1:0] i_rdAddr,
    output decPkg::half_t                 o_rdData
);
    import decPkg::*;

    half_t mem [ChunkBeats];
    half_t rdData;

    always_ff @(posedge i_clk) begin
        if (i_wrEn) begin
            mem[i_wrAddr] <= i_wrData;
        end
    end

    // output holds its value between reads.
    always_ff @(posedge i_clk) begin
        if (i_rdEn) begin
            rdData <= mem[i_rdAddr];
        end
    end

    assign o_rdData = rdData;

endmodule

// ==== design/pageDecoder.sv ====
`timescale 1ns/10ps

module pageDecoder #(
    parameter int ChunkBeats = 16
) (
    input  logic               i_clk,
    input  logic               i_rstN,
    input  logic               i_dataValid,
    input  decPkg::word_t      i_data,
    output logic               o_dataReady,
    output logic               o_decoderReady,
    output logic               o_syndromeValid,
    output decPkg::syndromes_t o_syndromes,
    output logic               o_decodeNeeded,
    input  logic               i_elpValid,
    input  decPkg::elp_t       i_elp,
    input  logic               i_forward,
    output logic               o_outValid,
    output decPkg::word_t      o_outData,
    output logic               o_outLast,
    input  logic               i_outReady
);
    import decPkg::*;

    localparam int AddrWidth = $clog2(ChunkBeats);

    logic                 wInValid;
    half_t                wInBeat;
    logic                 wInReady;
    logic                 wWrEn;
    logic [AddrWidth-1:0] wWrAddr;
    half_t                wWrData;
    logic                 wRdEn;
    logic [AddrWidth-1:0] wRdAddr;
    half_t                wRdData;
    logic                 wOutValid;
    halfBeat_t            wOutBeat;
    logic                 wOutReady;
    logic                 wRelease;
    logic                 elpPending;
    logic                 elpAccept;

    // the solver may answer in the same cycle it sees the strobe.
    assign elpAccept      = i_elpValid && (elpPending || o_syndromeValid);
    assign o_decoderReady = wInReady;

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            elpPending <= 1'b0;
        end else if (elpAccept) begin
            elpPending <= 1'b0;
        end else if (o_syndromeValid) begin
            elpPending <= 1'b1;
        end
    end

    downConverter u_downConverter (
        .i_clk(i_clk), .i_rstN(i_rstN),
        .i_srcValid(i_dataValid), .i_srcData(i_data), .o_srcReady(o_dataReady),
        .o_beatValid(wInValid), .o_beat(wInBeat), .i_beatReady(wInReady)
    );

    syndromeCalc #(.ChunkBeats(ChunkBeats)) u_syndromeCalc (
        .i_clk(i_clk), .i_rstN(i_rstN),
        .i_beatValid(wInValid), .i_beat(wInBeat), .o_beatReady(wInReady),
        .i_release(wRelease),
        .o_wrEn(wWrEn), .o_wrAddr(wWrAddr), .o_wrData(wWrData),
        .o_syndromeValid(o_syndromeValid), .o_syndromes(o_syndromes),
        .o_decodeNeeded(o_decodeNeeded)
    );

    messageBuffer #(.ChunkBeats(ChunkBeats)) u_messageBuffer (
        .i_clk(i_clk),
        .i_wrEn(wWrEn), .i_wrAddr(wWrAddr), .i_wrData(wWrData),
        .i_rdEn(wRdEn), .i_rdAddr(wRdAddr), .o_rdData(wRdData)
    );

    chienCorrector #(.ChunkBeats(ChunkBeats)) u_chienCorrector (
        .i_clk(i_clk), .i_rstN(i_rstN),
        .i_elpValid(elpAccept), .i_elp(i_elp), .i_forward(i_forward),
        .o_rdEn(wRdEn), .o_rdAddr(wRdAddr), .i_rdData(wRdData),
        .o_beatValid(wOutValid), .o_beat(wOutBeat), .i_beatReady(wOutReady),
        .o_release(wRelease)
    );

    upConverter u_upConverter (
        .i_clk(i_clk), .i_rstN(i_rstN),
        .i_beatValid(wOutValid), .i_beat(wOutBeat), .o_beatReady(wOutReady),
        .o_outValid(o_outValid), .o_outData(o_outData), .o_outLast(o_outLast),
        .i_outReady(i_outReady)
    );

    // a locator with no chunk waiting for it is dropped.
    assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_elpValid |-> elpPending || o_syndromeValid)
        else $error("locator strobe arrived before any syndrome strobe");

endmodule

// ==== design/syndromeCalc.sv ====
`timescale 1ns/10ps

module syndromeCalc #(
    parameter int ChunkBeats = 16
) (
    input  logic                          i_clk,
    input  logic                          i_rstN,
    input  logic                          i_beatValid,
    input  decPkg::half_t                 i_beat,
    output logic                          o_beatReady,
    input  logic                          i_release,
    output logic                          o_wrEn,
    output logic [$clog2(ChunkBeats)-1:0] o_wrAddr,
    output decPkg::half_t                 o_wrData,
    output logic                          o_syndromeValid,
    output decPkg::syndromes_t            o_syndromes,
    output logic                          o_decodeNeeded
);
    import gfPkg::*;
    import decPkg::*;

    localparam int AddrWidth = $clog2(ChunkBeats);

    logic                     chunkOpen;
    logic                     take;
    logic                     lastBeat;
    logic                     synValid;
    logic [AddrWidth-1:0]     beatCnt;
    gfElem_t [1:NumSyndromes] acc;
    gfElem_t [1:NumSyndromes] contrib;

    assign o_beatReady = chunkOpen;
    assign take        = i_beatValid && chunkOpen;
    assign lastBeat    = (beatCnt == AddrWidth'(ChunkBeats - 1));

    // every beat lands at its own index.
    assign o_wrEn   = take;
    assign o_wrAddr = beatCnt;
    assign o_wrData = i_beat;

    // Sk of a beat is alpha^(16bk) times the in-beat sum over alpha^(kj).
    always_comb begin : beatContrib
        gfElem_t inner;
        for (int k = 1; k <= NumSyndromes; k++) begin
            inner = '0;
            for (int j = 0; j < HalfWidth; j++) begin
                if (i_beat[j]) begin
                    inner = inner ^ gfAlphaPow(k * j);
                end
            end
            contrib[k] = gfMul(inner, gfAlphaPow(HalfWidth * k * beatCnt));
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            acc <= (beatCnt == '0) ? contrib : (acc ^ contrib);   // first beat restarts.
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            chunkOpen <= 1'b1;
            beatCnt   <= '0;
            synValid  <= 1'b0;
        end else begin
            synValid <= take && lastBeat;
            if (take) begin
                beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
            end
            if (take && lastBeat) begin
                chunkOpen <= 1'b0;
            end else if (i_release) begin
                chunkOpen <= 1'b1;   // buffer drained by the corrector.
            end
        end
    end

    assign o_syndromeValid = synValid;
    assign o_syndromes     = syndromes_t'(acc);
    assign o_decodeNeeded  = |acc;

    // the buffer is not touched again until the corrector lets go of it.
    assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_syndromeValid |-> !o_wrEn until i_release)
        else $error("syndromeCalc took a beat while the chunk was closed");

endmodule

// ==== design/upConverter.sv ====
`timescale 1ns/10ps

module upConverter (
    input  logic              i_clk,
    input  logic              i_rstN,
    input  logic              i_beatValid,
    input  decPkg::halfBeat_t i_beat,
    output logic              o_beatReady,
    output logic              o_outValid,
    output decPkg::word_t     o_outData,
    output logic              o_outLast,
    input  logic              i_outReady
);
    import decPkg::*;

    half_t lowReg;
    logic  haveLow;
    word_t outData;
    logic  outValid;
    logic  outLast;
    logic  take;

    // a new half is accepted only if the word slot frees up.
    assign o_beatReady = !outValid || i_outReady;
    assign take        = i_beatValid && o_beatReady;

    always_ff @(posedge i_clk) begin
        if (take && !haveLow) begin
            lowReg <= i_beat.data;
        end
        if (take && haveLow) begin
            outData <= {i_beat.data, lowReg};   // first half is the low half.
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            haveLow  <= 1'b0;
            outValid <= 1'b0;
            outLast  <= 1'b0;
        end else begin
            if (take) begin
                haveLow <= !haveLow;
            end
            if (take && haveLow) begin
                outValid <= 1'b1;
                outLast  <= i_beat.last;
            end else if (i_outReady) begin
                outValid <= 1'b0;
                outLast  <= 1'b0;
            end
        end
    end

    assign o_outValid = outValid;
    assign o_outData  = outData;
    assign o_outLast  = outLast;

endmodule

// ==== dv/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] Seed    = 32'h390f310f;
localparam logic [9:0]  TbPoly  = 10'h211;   // x^9 + x^4 + 1.
localparam int          TbOrder = 511;

logic [31:0] stimState  = Seed;
logic [31:0] readyState = Seed ^ 32'hffff_ffff;   // separate stream for back-pressure.
gfElem_t     alphaTab [0:TbOrder-1];
int unsigned errPos [4];
int          errCount;

function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] stimRand();
    stimState = lcgNext(stimState);
    return stimState;
endfunction

// upper bits only, the low bits of an lcg cycle quickly.
function automatic int unsigned randBelow(int unsigned n);
    return (stimRand() >> 16) % n;
endfunction

// plain polynomial product, then fold the high terms back.
function automatic gfElem_t tbGfMul(gfElem_t a, gfElem_t b);
    logic [16:0] prod;
    prod = '0;
    for (int i = 0; i < 9; i++) begin
        if (b[i]) begin
            prod = prod ^ ({8'b0, a} << i);
        end
    end
    for (int i = 16; i >= 9; i--) begin
        if (prod[i]) begin
            prod = prod ^ ({7'b0, TbPoly} << (i - 9));
        end
    end
    return prod[8:0];
endfunction

task automatic buildAlphaTable();
    alphaTab[0] = 9'd1;
    for (int i = 1; i < TbOrder; i++) begin
        alphaTab[i] = tbGfMul(alphaTab[i-1], 9'd2);
    end
endtask

function automatic gfElem_t tbAlphaPow(int unsigned e);
    return alphaTab[e % TbOrder];
endfunction

function automatic syndromes_t calcSyndromes(logic [ChunkBits-1:0] chunk);
    gfElem_t s [1:NumSyndromes];
    for (int k = 1; k <= NumSyndromes; k++) begin
        s[k] = '0;
        for (int p = 0; p < ChunkBits; p++) begin
            if (chunk[p]) begin
                s[k] = s[k] ^ tbAlphaPow(k * p);
            end
        end
    end
    return {s[1], s[2], s[3], s[4], s[5], s[6], s[7], s[8]};
endfunction

// product of (1 + alpha^p x) over the chosen positions.
function automatic elp_t buildLocator();
    gfElem_t c [0:NumElpCoef-1];
    c[0] = 9'd1;
    for (int i = 1; i < NumElpCoef; i++) begin
        c[i] = '0;
    end
    for (int e = 0; e < errCount; e++) begin
        for (int i = NumElpCoef - 1; i >= 1; i--) begin
            c[i] = c[i] ^ tbGfMul(c[i-1], tbAlphaPow(errPos[e]));
        end
    end
    return {c[0], c[1], c[2], c[3], c[4]};
endfunction

`endif

// ==== dv/tbPageDecoder.sv ====
`timescale 1ns/10ps

module tbPageDecoder;
    import gfPkg::*;
    import decPkg::*;

    localparam int ChunkBeats     = 16;
    localparam int ChunkBits      = ChunkBeats * HalfWidth;
    localparam int WordsPerChunk  = ChunkBeats / 2;
    localparam int NumChunks      = 40;
    localparam int CyclesPerChunk = 400;

    logic       i_clk = 1'b0;
    logic       i_rstN;
    logic       i_dataValid;
    word_t      i_data;
    logic       o_dataReady;
    logic       o_decoderReady;
    logic       o_syndromeValid;
    syndromes_t o_syndromes;
    logic       o_decodeNeeded;
    logic       i_elpValid;
    elp_t       i_elp;
    logic       i_forward;
    logic       o_outValid;
    word_t      o_outData;
    logic       o_outLast;
    logic       i_outReady;

    word_t                expWords [$];
    int                   outCount = 0;
    logic [ChunkBits-1:0] chunkData;
    logic [ChunkBits-1:0] chunkOut;
    syndromes_t           expSyn;
    logic                 fwdFlag;

    `include "tbModel.svh"

    pageDecoder #(.ChunkBeats(ChunkBeats)) u_pageDecoder (
        .i_clk(i_clk), .i_rstN(i_rstN),
        .i_dataValid(i_dataValid), .i_data(i_data), .o_dataReady(o_dataReady),
        .o_decoderReady(o_decoderReady),
        .o_syndromeValid(o_syndromeValid), .o_syndromes(o_syndromes),
        .o_decodeNeeded(o_decodeNeeded),
        .i_elpValid(i_elpValid), .i_elp(i_elp), .i_forward(i_forward),
        .o_outValid(o_outValid), .o_outData(o_outData), .o_outLast(o_outLast),
        .i_outReady(i_outReady)
    );

    always #50 i_clk = ~i_clk;

    task automatic failRun(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareSyndromes(string name, syndromes_t got, syndromes_t exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic pickErrors(int n);
        int unsigned p;
        logic        dup;
        errCount = 0;
        while (errCount < n) begin
            p   = randBelow(ChunkBits);
            dup = 1'b0;
            for (int i = 0; i < errCount; i++) begin
                dup = dup || (errPos[i] == p);
            end
            if (!dup) begin
                errPos[errCount] = p;
                errCount++;
            end
        end
    endtask

    // chunk 0 is all zero. then a mix of locator 1, forwarding and real errors.
    task automatic makeChunk(int c);
        int mode;
        mode = (c == 0) ? 0 : randBelow(8);
        for (int w = 0; w < WordsPerChunk; w++) begin
            chunkData[WordWidth*w +: WordWidth] = (mode == 0) ? '0 : stimRand();
        end
        fwdFlag = (mode == 2);
        if (mode < 2) begin
            pickErrors(0);
        end else begin
            pickErrors(1 + randBelow(4));
        end
        chunkOut = chunkData;
        for (int e = 0; e < errCount; e++) begin
            if (!fwdFlag) begin
                chunkOut[errPos[e]] = ~chunkOut[errPos[e]];
            end
        end
        for (int w = 0; w < WordsPerChunk; w++) begin
            expWords.push_back(chunkOut[WordWidth*w +: WordWidth]);
        end
    endtask

    // entered on a falling edge, ready is sampled there.
    task automatic sendWord(word_t w);
        logic taken;
        i_dataValid = 1'b1;
        i_data      = w;
        taken       = 1'b0;
        while (!taken) begin
            taken = o_dataReady;
            @(negedge i_clk);
        end
        i_dataValid = 1'b0;
    endtask

    initial begin : mainFlow
        i_rstN      = 1'b0;
        i_dataValid = 1'b0;
        i_data      = '0;
        i_elpValid  = 1'b0;
        i_elp       = '0;
        i_forward   = 1'b0;
        i_outReady  = 1'b0;
        buildAlphaTable();
        repeat (3) @(negedge i_clk);
        i_rstN = 1'b1;
        compareFlag("o_dataReady", o_dataReady, 1'b0);
        compareFlag("o_outValid", o_outValid, 1'b0);
        compareFlag("o_decoderReady", o_decoderReady, 1'b1);
        for (int c = 0; c < NumChunks; c++) begin
            makeChunk(c);
            for (int w = 0; w < WordsPerChunk; w++) begin
                sendWord(chunkData[WordWidth*w +: WordWidth]);
            end
            while (!o_syndromeValid) begin
                @(negedge i_clk);
            end
            expSyn = calcSyndromes(chunkData);
            compareSyndromes("o_syndromes", o_syndromes, expSyn);
            compareFlag("o_decodeNeeded", o_decodeNeeded, |expSyn);
            compareFlag("o_decoderReady", o_decoderReady, 1'b0);   // chunk is closed now.
            i_elpValid = 1'b1;   // answer inside the strobe cycle.
            i_elp      = buildLocator();
            i_forward  = fwdFlag;
            @(negedge i_clk);
            i_elpValid = 1'b0;
            compareFlag("o_syndromeValid", o_syndromeValid, 1'b0);
        end
        while (outCount < NumChunks * WordsPerChunk) begin
            @(negedge i_clk);
        end
        // last word has been taken, the buffer is free again.
        @(negedge i_clk);
        compareFlag("o_decoderReady", o_decoderReady, 1'b1);
        compareFlag("o_outValid", o_outValid, 1'b0);
        $display("TEST PASS");
        $finish;
    end

    // ready holds through the next rising edge, so a word seen here is taken there.
    always @(negedge i_clk) begin : outputCheck
        readyState = lcgNext(readyState);
        i_outReady = (readyState[21:20] != 2'b00);
        if (!o_outValid) begin
            compareFlag("o_outLast", o_outLast, 1'b0);
        end else if (i_outReady) begin
            if (expWords.size() == 0) begin
                failRun("an output word arrived when none was expected");
            end else begin
                compareWord("o_outData", o_outData, expWords.pop_front());
                compareFlag("o_outLast", o_outLast,
                    (outCount % WordsPerChunk) == WordsPerChunk - 1);
                outCount++;
            end
        end
    end

    initial begin : watchdog
        repeat (NumChunks * CyclesPerChunk) @(posedge i_clk);
        failRun($sformatf("run timed out after %0d clock cycles",
            NumChunks * CyclesPerChunk));
    end

endmodule

// ==== sim.f ====
+incdir+dv
design/gfPkg.sv
design/decPkg.sv
design/downConverter.sv
design/syndromeCalc.sv
design/messageBuffer.sv
design/chienCorrector.sv
design/upConverter.sv
design/pageDecoder.sv
dv/tbPageDecoder.sv
